// File: verilog.f
source/mmio_csr_pkg.sv
source/mmio_req_queue.sv
source/feature_csr_block.sv
source/csr_read_mux.sv
source/mmio_csr_manager.sv
verif/tb_mmio_csr_manager.sv

// File: verif/tb_mmio_csr_manager.sv
// MMIO CSR manager testbench with clock, reset, stimulus, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_mmio_csr_manager
    import mmio_csr_pkg::*;
;

    localparam int             BASE_ADDR      = 'h100;
    localparam int             NEXT_ADDR      = 0;
    localparam int             N_FEATURES     = 3;
    localparam logic [2:0]     FEATURE_ENABLE = 3'b101;
    localparam int             WIN_DW         = N_FEATURES * FEATURE_WINDOW_DW;
    localparam int             TIMEOUT_CYCLES = 4000;
    localparam int             DRAIN_LIMIT    = 400;
    localparam time            DRIVE_DELAY    = 1;

    // Expected manager response, kept in request order
    typedef struct packed {
        mmio_tid_t tid;
        csr_data_t data;
    } exp_rsp_t;

    logic          clk;
    logic          reset;
    mmio_rx_t      host_rx;
    mmio_rsp_t     afu_rsp;
    mmio_rsp_t     host_rsp;
    feature_ctrl_t feature_ctrl [N_FEATURES];

    integer        seed;
    int            cycle_count;
    int            issued;
    logic          afu_random;
    mmio_rsp_t     afu_prev;
    exp_rsp_t      exp_q [$];
    logic [7:0]    model_mode  [N_FEATURES];
    csr_data_t     model_tbase [N_FEATURES];
    logic          model_tvalid [N_FEATURES];
    logic [31:0]   model_hi    [N_FEATURES];

    mmio_csr_manager #(
        .BASE_ADDR      (BASE_ADDR),
        .NEXT_ADDR      (NEXT_ADDR),
        .N_FEATURES     (N_FEATURES),
        .FEATURE_ENABLE (FEATURE_ENABLE),
        .QUEUE_DEPTH    (16)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .host_rx      (host_rx),
        .afu_rsp      (afu_rsp),
        .host_rsp     (host_rsp),
        .feature_ctrl (feature_ctrl)
    );

    // 100 ns clock period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================================================
    // Failure reporting and watchdog
    // ============================================================

    task automatic flag_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic stop_on_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_on_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    // ============================================================
    // Reference model
    // ============================================================

    // Register contents as the host should see them, from the window layout and past writes
    function automatic csr_data_t expected_read(input int ofs);
        int           f;
        int           r;
        logic [127:0] uid;
        csr_data_t    dfh;
        f   = ofs / FEATURE_WINDOW_DW;
        r   = ofs % FEATURE_WINDOW_DW;
        uid = FEATURE_ENABLE[f] ? FEATURE_UID[f] : 128'b0;
        // Header fields placed one by one, type in the top nibble
        dfh          = '0;
        dfh[63:60]   = 4'd2;
        // Only the last feature ends the list when nothing follows the manager
        dfh[40]      = (f == N_FEATURES - 1) && (NEXT_ADDR == 0);
        dfh[39:16]   = 24'(FEATURE_WINDOW_DW * 4);
        case (r)
            0:       return dfh;
            2:       return uid[63:0];
            4:       return uid[127:64];
            8:       return {56'b0, model_mode[f]};
            10:      return model_tbase[f];
            default: return 64'b0;
        endcase
    endfunction

    // Split base writes send the high half to the odd dword first
    function automatic void model_write(input mmio_addr_t addr, input csr_data_t data,
                                        input logic len32);
        int f;
        int r;
        f = (int'(addr) - BASE_ADDR) / FEATURE_WINDOW_DW;
        r = (int'(addr) - BASE_ADDR) % FEATURE_WINDOW_DW;
        if (r == REG_MODE)
        begin
            model_mode[f] = data[7:0];
        end
        else if (r == REG_TABLE_BASE + 1 && len32)
        begin
            model_hi[f]     = data[31:0];
            model_tvalid[f] = 1'b0;
        end
        else if (r == REG_TABLE_BASE)
        begin
            model_tbase[f]  = len32 ? {model_hi[f], data[31:0]} : data;
            model_tvalid[f] = 1'b1;
        end
    endfunction

    // ============================================================
    // Stimulus helpers
    // ============================================================

    // Ends the current cycle; user logic may answer at random while afu_random is set
    task automatic next_cycle();
        if (afu_random && (($random(seed) & 3) < 2))
        begin
            afu_rsp.valid = 1'b1;
            afu_rsp.tid   = mmio_tid_t'($random(seed));
            afu_rsp.data  = {$random(seed), $random(seed)};
        end
        @(posedge clk);
        #DRIVE_DELAY;
        host_rx = '0;
        afu_rsp = '0;
    endtask

    task automatic write_csr(input mmio_addr_t addr, input csr_data_t data, input logic len32);
        host_rx       = '0;
        host_rx.wr    = 1'b1;
        host_rx.len32 = len32;
        host_rx.addr  = addr;
        host_rx.data  = data;
        model_write(addr, data, len32);
        next_cycle();
    endtask

    // Only reads inside the window expect a manager response
    task automatic read_csr(input mmio_addr_t addr);
        exp_rsp_t exp;
        int       ofs;
        ofs          = int'(addr) - BASE_ADDR;
        host_rx      = '0;
        host_rx.rd   = 1'b1;
        host_rx.addr = addr;
        host_rx.tid  = mmio_tid_t'($random(seed));
        if (ofs >= 0 && ofs < WIN_DW)
        begin
            exp.tid  = host_rx.tid;
            exp.data = expected_read(ofs);
            exp_q.push_back(exp);
        end
        next_cycle();
    endtask

    // Every outstanding read must be answered within a bounded number of cycles
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            next_cycle();
            waited = waited + 1;
        end
        if (exp_q.size() != 0)
        begin
            stop_on_error($sformatf("%0d manager read responses never arrived",
                                    exp_q.size()));
        end
    endtask

    task automatic check_ctrl(input int f);
        assert (feature_ctrl[f].mode == model_mode[f])
        else flag_mismatch($sformatf("feature_ctrl[%0d].mode", f),
                           model_mode[f], feature_ctrl[f].mode);
        assert (feature_ctrl[f].table_base_valid == model_tvalid[f])
        else flag_mismatch($sformatf("feature_ctrl[%0d].table_base_valid", f),
                           model_tvalid[f], feature_ctrl[f].table_base_valid);
        // The base itself is only meaningful once marked valid
        if (model_tvalid[f])
        begin
            assert (feature_ctrl[f].table_base == model_tbase[f])
            else flag_mismatch($sformatf("feature_ctrl[%0d].table_base", f),
                               model_tbase[f], feature_ctrl[f].table_base);
        end
    endtask

    // ============================================================
    // Response checking
    // ============================================================

    // Output register must come out of reset idle
    assert property (@(posedge clk) reset |=> !host_rsp.valid)
    else flag_mismatch("host_rsp.valid", 0, $sampled(host_rsp.valid));

    always @(posedge clk)
    begin
        afu_prev <= afu_rsp;
    end

    // Outputs are settled at the falling edge; a user-logic response owns the output
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (afu_prev.valid)
            begin
                assert (host_rsp == afu_prev)
                else flag_mismatch("host_rsp", afu_prev, host_rsp);
            end
            else if (host_rsp.valid)
            begin
                assert (exp_q.size() != 0)
                else stop_on_error("manager response on host_rsp with no read outstanding");
                if (exp_q.size() != 0)
                begin
                    assert (host_rsp.tid == exp_q[0].tid)
                    else flag_mismatch("host_rsp.tid", exp_q[0].tid, host_rsp.tid);
                    assert (host_rsp.data == exp_q[0].data)
                    else flag_mismatch("host_rsp.data", exp_q[0].data, host_rsp.data);
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        seed        = 55239;
        cycle_count = 0;
        afu_random  = 1'b0;
        reset       = 1'b1;
        host_rx     = '0;
        afu_rsp     = '0;
        for (int f = 0; f < N_FEATURES; f++)
        begin
            model_mode[f]   = 8'b0;
            model_tbase[f]  = 64'b0;
            model_tvalid[f] = 1'b0;
            model_hi[f]     = 32'b0;
        end
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Idle state straight after reset
        assert (host_rsp.valid == 1'b0)
        else flag_mismatch("host_rsp.valid", 0, host_rsp.valid);
        for (int f = 0; f < N_FEATURES; f++)
        begin
            check_ctrl(f);
        end

        // Headers and identifiers of every window, absent feature included
        for (int f = 0; f < N_FEATURES; f++)
        begin
            read_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_DFH));
            read_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_ID_L));
            read_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_ID_H));
        end
        wait_drained();

        // Full-width mode and base writes, then read back
        for (int f = 0; f < N_FEATURES; f++)
        begin
            write_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_MODE),
                      {$random(seed), $random(seed)}, 1'b0);
            check_ctrl(f);
            write_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_TABLE_BASE),
                      {$random(seed), $random(seed)}, 1'b0);
            check_ctrl(f);
            read_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_MODE));
            read_csr(mmio_addr_t'(BASE_ADDR + f * FEATURE_WINDOW_DW + REG_TABLE_BASE));
        end
        wait_drained();

        // Split base write on feature 1, high half first
        write_csr(mmio_addr_t'(BASE_ADDR + FEATURE_WINDOW_DW + REG_TABLE_BASE + 1),
                  {32'b0, $random(seed)}, 1'b1);
        check_ctrl(1);
        write_csr(mmio_addr_t'(BASE_ADDR + FEATURE_WINDOW_DW + REG_TABLE_BASE),
                  {32'b0, $random(seed)}, 1'b1);
        check_ctrl(1);
        read_csr(mmio_addr_t'(BASE_ADDR + FEATURE_WINDOW_DW + REG_TABLE_BASE));
        wait_drained();

        // Burst of 16 in-window reads mixed with reads that user logic answers
        afu_random = 1'b1;
        issued     = 0;
        while (issued < 16)
        begin
            if (($random(seed) & 3) == 0)
            begin
                read_csr(mmio_addr_t'((($random(seed) & 1) ? 'h200 : 'h080)
                                      + {$random(seed)} % 64));
            end
            else
            begin
                read_csr(mmio_addr_t'(BASE_ADDR + {$random(seed)} % WIN_DW));
                issued = issued + 1;
            end
        end
        wait_drained();
        // Quiet tail, any further manager response is one too many
        afu_random = 1'b0;
        repeat (10) next_cycle();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/mmio_csr_manager.sv
// Top level of the MMIO CSR manager: request queue, feature register blocks and read mux
`timescale 1ns/1ps
`default_nettype none

module mmio_csr_manager
    import mmio_csr_pkg::*;
#(
    // Window base as a dword address
    parameter int BASE_ADDR   = 0,
    // Byte address of the next feature outside the manager, 0 ends the list
    parameter int NEXT_ADDR   = 0,
    parameter int N_FEATURES  = 1,
    parameter logic [N_FEATURES-1:0] FEATURE_ENABLE = '1,
    parameter int QUEUE_DEPTH = 16
)
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire mmio_rx_t  host_rx,
    input  wire mmio_rsp_t afu_rsp,
    output mmio_rsp_t      host_rsp,
    output feature_ctrl_t  feature_ctrl [N_FEATURES]
);

    csr_rd_req_t           rd_head;
    logic                  head_valid;
    logic                  pop;
    logic [N_FEATURES-1:0] hit;
    csr_data_t             hit_data [N_FEATURES];

    // ============================================================
    // Read request queue
    // ============================================================

    mmio_req_queue #(
        .BASE_ADDR   (BASE_ADDR),
        .N_FEATURES  (N_FEATURES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_req_queue (
        .clk        (clk),
        .reset      (reset),
        .host_rx    (host_rx),
        .pop        (pop),
        .rd_head    (rd_head),
        .head_valid (head_valid)
    );

    // ============================================================
    // Feature register blocks, one window each
    // ============================================================

    // Every block sees raw host writes and the queue head; only the last closes the list
    for (genvar i = 0; i < N_FEATURES; i++)
    begin : g_feature
        feature_csr_block #(
            .BASE_ADDR     (BASE_ADDR),
            .FEATURE_INDEX (i),
            .PRESENT       (FEATURE_ENABLE[i]),
            .IS_LAST       (i == N_FEATURES - 1),
            .NEXT_ADDR     (NEXT_ADDR)
        ) u_feature (
            .clk      (clk),
            .reset    (reset),
            .host_rx  (host_rx),
            .rd_head  (rd_head),
            .ctrl     (feature_ctrl[i]),
            .hit      (hit[i]),
            .hit_data (hit_data[i])
        );
    end

    // Response path, shared with user logic
    csr_read_mux #(
        .N_FEATURES (N_FEATURES)
    ) u_read_mux (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .rd_head    (rd_head),
        .hit        (hit),
        .hit_data   (hit_data),
        .afu_rsp    (afu_rsp),
        .pop        (pop),
        .host_rsp   (host_rsp)
    );

endmodule

`default_nettype wire

// File: source/csr_read_mux.sv
// Read-hit select, one-entry holding register and host response arbitration
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux
    import mmio_csr_pkg::*;
#(
    parameter int N_FEATURES = 1
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  head_valid,
    input  wire csr_rd_req_t           rd_head,
    input  wire logic [N_FEATURES-1:0] hit,
    input  wire csr_data_t             hit_data [N_FEATURES],
    input  wire mmio_rsp_t             afu_rsp,
    output logic                       pop,
    output mmio_rsp_t                  host_rsp
);

    csr_data_t sel_data;
    logic      hold_valid;
    mmio_tid_t hold_tid;
    csr_data_t hold_data;
    logic      drain;
    logic      rsp_valid;
    mmio_tid_t rsp_tid;
    csr_data_t rsp_data;

    // At most one feature claims an offset, so an OR over the masked words selects it
    // An in-window offset nobody claims reads as zero
    always_comb
    begin
        sel_data = '0;
        for (int i = 0; i < N_FEATURES; i++)
        begin
            if (hit[i])
            begin
                sel_data = sel_data | hit_data[i];
            end
        end
    end

    // ============================================================
    // Holding register
    // ============================================================

    // Head moves into the holding register only when it is empty
    assign pop   = head_valid && !hold_valid;
    // User-logic responses own the output, so the held entry waits for an idle cycle
    assign drain = hold_valid && !afu_rsp.valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hold_valid <= 1'b0;
        end
        else if (pop)
        begin
            hold_valid <= 1'b1;
        end
        else if (drain)
        begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            hold_tid  <= rd_head.tid;
            hold_data <= sel_data;
        end
    end

    // ============================================================
    // Registered host output
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= afu_rsp.valid || hold_valid;
        end
    end

    // afu_rsp is passed through unchanged whenever it is valid
    always_ff @(posedge clk)
    begin
        rsp_tid  <= afu_rsp.valid ? afu_rsp.tid : hold_tid;
        rsp_data <= afu_rsp.valid ? afu_rsp.data : hold_data;
    end

    assign host_rsp.valid = rsp_valid;
    assign host_rsp.tid   = rsp_tid;
    assign host_rsp.data  = rsp_data;

endmodule

`default_nettype wire

// File: source/feature_csr_block.sv
// One feature's control registers: write decode, split-write assembly and read decode
`timescale 1ns/1ps
`default_nettype none

module feature_csr_block
    import mmio_csr_pkg::*;
#(
    parameter int BASE_ADDR     = 0,
    parameter int FEATURE_INDEX = 0,
    parameter bit PRESENT       = 1'b1,
    parameter bit IS_LAST       = 1'b0,
    parameter int NEXT_ADDR     = 0
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire mmio_rx_t    host_rx,
    input  wire csr_rd_req_t rd_head,
    output feature_ctrl_t    ctrl,
    output logic             hit,
    output csr_data_t        hit_data
);

    // ============================================================
    // Placement of this feature
    // ============================================================

    // Window origin, as an absolute dword address and as an offset from the manager base
    localparam int OWN_DW  = BASE_ADDR + FEATURE_INDEX * FEATURE_WINDOW_DW;
    localparam int WIN_OFS = FEATURE_INDEX * FEATURE_WINDOW_DW;
    localparam int OWN_BYTE_BASE = OWN_DW * 4;
    localparam int WIN_BYTES     = FEATURE_WINDOW_DW * 4;

    // The last block either points outside the manager or terminates the list
    localparam bit DFH_EOL  = IS_LAST && (NEXT_ADDR == 0);
    localparam int DFH_NEXT = (IS_LAST && (NEXT_ADDR != 0)) ? NEXT_ADDR - OWN_BYTE_BASE
                                                            : WIN_BYTES;
    localparam csr_data_t DFH_WORD = {FTYPE_BBB, 19'b0, DFH_EOL, 24'(DFH_NEXT), 16'b0};

    // Absent features still answer, but with an all-zero identifier
    localparam logic [127:0] UID = PRESENT ? FEATURE_UID[FEATURE_INDEX] : 128'b0;

    localparam mmio_addr_t MODE_ADDR  = mmio_addr_t'(OWN_DW + REG_MODE);
    localparam mmio_addr_t TBASE_ADDR = mmio_addr_t'(OWN_DW + REG_TABLE_BASE);

    // ============================================================
    // Host writes
    // ============================================================

    mmio_addr_t  wr_addr_even;
    logic        wr_mode;
    logic        wr_tbase;
    logic [31:0] tbase_hi;
    logic        in_window;
    csr_offset_t local_ofs;

    // A 64-bit register may be hit on either of its dwords, so bit 0 is ignored
    assign wr_addr_even = {host_rx.addr[15:1], 1'b0};
    assign wr_mode      = host_rx.wr && (wr_addr_even == MODE_ADDR);
    assign wr_tbase     = host_rx.wr && (wr_addr_even == TBASE_ADDR);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl.mode             <= '0;
            ctrl.table_base_valid <= 1'b0;
        end
        else
        begin
            // Mode lives in the low dword, so a 32-bit write to the odd dword is ignored
            if (wr_mode && !(host_rx.len32 && host_rx.addr[0]))
            begin
                ctrl.mode <= host_rx.data[7:0];
            end
            if (wr_tbase)
            begin
                if (!host_rx.len32)
                begin
                    ctrl.table_base       <= host_rx.data;
                    ctrl.table_base_valid <= 1'b1;
                end
                else if (host_rx.addr[0])
                begin
                    // High half arrives first; the base is stale until the low half lands
                    ctrl.table_base_valid <= 1'b0;
                end
                else
                begin
                    ctrl.table_base       <= {tbase_hi, host_rx.data[31:0]};
                    ctrl.table_base_valid <= 1'b1;
                end
            end
        end
    end

    // Saved high half of a split table base write
    always_ff @(posedge clk)
    begin
        if (wr_tbase && host_rx.len32 && host_rx.addr[0])
        begin
            tbase_hi <= host_rx.data[31:0];
        end
    end

    // ============================================================
    // Read decode of the queue head
    // ============================================================

    assign in_window = (int'(rd_head.offset) >= WIN_OFS) &&
                       (int'(rd_head.offset) < WIN_OFS + FEATURE_WINDOW_DW);
    assign local_ofs = rd_head.offset - csr_offset_t'(WIN_OFS);

    always_comb
    begin
        hit      = 1'b0;
        hit_data = '0;
        if (in_window)
        begin
            hit = 1'b1;
            case (local_ofs)
                REG_DFH:        hit_data = DFH_WORD;
                REG_ID_L:       hit_data = UID[63:0];
                REG_ID_H:       hit_data = UID[127:64];
                REG_MODE:       hit_data = csr_data_t'(ctrl.mode);
                REG_TABLE_BASE: hit_data = ctrl.table_base;
                // Unmapped offsets are left to the mux, which answers with zero
                default:        hit = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/mmio_req_queue.sv
// Host request register, window filter and circular queue of pending CSR reads
`timescale 1ns/1ps
`default_nettype none

module mmio_req_queue
    import mmio_csr_pkg::*;
#(
    parameter int BASE_ADDR   = 0,
    parameter int N_FEATURES  = 1,
    parameter int QUEUE_DEPTH = 16
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire mmio_rx_t    host_rx,
    input  wire logic        pop,
    output csr_rd_req_t      rd_head,
    output logic             head_valid
);

    localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    // Total dword span covered by all feature windows
    localparam int WIN_DW = N_FEATURES * FEATURE_WINDOW_DW;

    // Advance a ring pointer, wrapping at the queue depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        n = (int'(p) == QUEUE_DEPTH - 1) ? '0 : p + 1'b1;
        return n;
    endfunction

    mmio_rx_t         rx_q;
    logic             in_window;
    logic             enq;
    csr_rd_req_t      enq_req;
    csr_rd_req_t      mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Incoming strobes are registered once for timing; only the strobe bits need reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_q.rd <= 1'b0;
            rx_q.wr <= 1'b0;
        end
        else
        begin
            rx_q <= host_rx;
        end
    end

    // Reads outside the window belong to user logic and are not queued
    assign in_window = (int'(rx_q.addr) >= BASE_ADDR) &&
                       (int'(rx_q.addr) < BASE_ADDR + WIN_DW);
    assign enq       = rx_q.rd && in_window;

    // Only the base-relative offset is kept, which is all the feature decode needs
    assign enq_req.offset = csr_offset_t'(rx_q.addr - mmio_addr_t'(BASE_ADDR));
    assign enq_req.tid    = rx_q.tid;

    // Storage ring; the host never has more than QUEUE_DEPTH reads outstanding
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= enq_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the fill level unchanged
            case ({enq, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible the cycle after it was written
    assign rd_head    = mem[rd_ptr];
    assign head_valid = (count != '0);

endmodule

`default_nettype wire

// File: source/mmio_csr_pkg.sv
// Types, register offsets, feature type code and feature identifiers for the MMIO CSR manager
`default_nettype none

package mmio_csr_pkg;

    // ============================================================
    // Widths that carry a meaning
    // ============================================================

    // Host MMIO addresses count dwords, so the low two byte bits are never sent
    typedef logic [15:0] mmio_addr_t;

    // Dword offset from the manager's base, wide enough for four windows
    typedef logic [7:0]  csr_offset_t;

    // Host request tag, returned unchanged with the read data
    typedef logic [8:0]  mmio_tid_t;

    // One 64-bit register word
    typedef logic [63:0] csr_data_t;

    // ============================================================
    // Host and user-logic traffic
    // ============================================================

    // One host MMIO strobe; rd and wr are never high together
    // A 32-bit write carries its dword in data[31:0]
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic       len32;
        mmio_addr_t addr;
        mmio_tid_t  tid;
        csr_data_t  data;
    } mmio_rx_t;

    // Read response, used both by user logic and on the host output
    typedef struct packed {
        logic      valid;
        mmio_tid_t tid;
        csr_data_t data;
    } mmio_rsp_t;

    // A queued in-window read, already made relative to the manager's base
    typedef struct packed {
        csr_offset_t offset;
        mmio_tid_t   tid;
    } csr_rd_req_t;

    // Controls handed to one shim
    typedef struct packed {
        logic [7:0] mode;
        csr_data_t  table_base;
        logic       table_base_valid;
    } feature_ctrl_t;

    // ============================================================
    // Register map of one feature window
    // ============================================================

    // Each feature owns 16 dwords, i.e. 64 bytes of MMIO space
    localparam int FEATURE_WINDOW_DW = 16;

    localparam csr_offset_t REG_DFH        = 8'd0;
    localparam csr_offset_t REG_ID_L       = 8'd2;
    localparam csr_offset_t REG_ID_H       = 8'd4;
    localparam csr_offset_t REG_MODE       = 8'd8;
    localparam csr_offset_t REG_TABLE_BASE = 8'd10;

    // Feature type reported in DFH bits 63:60 (building block)
    localparam logic [3:0] FTYPE_BBB = 4'd2;

    // Identifiers of the features, indexed by feature number
    localparam int MAX_FEATURES = 4;
    localparam logic [127:0] FEATURE_UID [MAX_FEATURES] = '{
        128'h3f1d7a62_8c04_4e19_b2a5_90d6c17e4b28,
        128'h71e0c9b4_2a5f_4d83_9e16_c84b0f2d5a73,
        128'hb58a43d1_e7c2_4f60_8d39_1a6f72c0e945,
        128'h0c9e61f7_54b3_42da_a1c8_e3075d9b26f4
    };

endpackage

`default_nettype wire
